/* noc_pkg.sv */
/*
 * Mesh-level definitions for the router
 *   xy_t        router and destination coordinates
 *   port_e      port index of the five router ports
 *   direction_t one-hot output selector with its codes
 *   next_hop    XY dimension-order routing step
 */
package noc_pkg;

  // Coordinates on the mesh, north is y minus one and east is x plus one
  typedef struct packed {
    logic [2:0] x;
    logic [2:0] y;
  } xy_t;

  typedef enum logic [2:0] {
    kNorthPort = 3'd0,
    kSouthPort = 3'd1,
    kWestPort  = 3'd2,
    kEastPort  = 3'd3,
    kLocalPort = 3'd4
  } port_e;

  localparam int unsigned NumPorts = 5;

  // One bit per output, same order as port_e
  typedef logic [NumPorts-1:0] direction_t;

  localparam direction_t GoNorth = 5'b00001;
  localparam direction_t GoSouth = 5'b00010;
  localparam direction_t GoWest  = 5'b00100;
  localparam direction_t GoEast  = 5'b01000;
  localparam direction_t GoLocal = 5'b10000;

  // X first, then Y, then eject on the local port
  function automatic direction_t next_hop(input xy_t position, input xy_t destination);
    direction_t dir;
    if (destination.x > position.x) begin
      dir = GoEast;
    end else if (destination.x < position.x) begin
      dir = GoWest;
    end else if (destination.y < position.y) begin
      dir = GoNorth;
    end else if (destination.y > position.y) begin
      dir = GoSouth;
    end else begin
      dir = GoLocal;
    end
    return dir;
  endfunction

endpackage

/* flit_pkg.sv */
/*
 * Flit format on every router link
 *   preamble_t  head and tail marks
 *   message_t   message type, passed through untouched
 *   header_t    head flit layout with the look-ahead routing field
 *   flit_t      header view and plain payload view of one flit word
 */
package flit_pkg;

  // Data bits per flit, the preamble comes on top
  localparam int unsigned FlitDataWidth = 32;

  typedef struct packed {
    logic head;
    logic tail;
  } preamble_t;

  typedef logic [4:0] message_t;

  // Whatever is left of the data word after the header fields
  localparam int unsigned ReservedWidth = FlitDataWidth - 2 * $bits(noc_pkg::xy_t)
                                          - $bits(message_t) - $bits(noc_pkg::direction_t);

  // Routing sits in the low bits so the rewrite touches only those
  typedef struct packed {
    preamble_t                preamble;
    noc_pkg::xy_t             source;
    noc_pkg::xy_t             destination;
    message_t                 message;
    logic [ReservedWidth-1:0] reserved;
    noc_pkg::direction_t      routing;
  } header_t;

  typedef logic [FlitDataWidth+1:0] payload_t;

  // Head flits are read through header, body flits through payload
  typedef union packed {
    header_t  header;
    payload_t payload;
  } flit_t;

endpackage

/* router_input_fifo.sv */
/*
 * Input queue for one router port
 *   circular buffer of flits with read and write pointers
 *   occupancy count driving the full and empty flags
 */
`timescale 1ns/10ps

module router_input_fifo #(
  parameter int unsigned FifoDepth = 4
) (
  input  logic            clk,
  input  logic            rst,
  input  flit_pkg::flit_t data_i,
  input  logic            wr_i,
  input  logic            rd_i,
  output flit_pkg::flit_t data_o,
  output logic            empty_o,
  output logic            full_o
);
  import flit_pkg::*;

  localparam int unsigned PtrWidth = $clog2(FifoDepth);

  // Storage, no reset needed on the payload
  flit_t mem [FifoDepth];

  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [PtrWidth:0]   count_q;
  logic                do_wr;
  logic                do_rd;

  // Illegal accesses are dropped here
  assign do_wr = wr_i & ~full_o;
  assign do_rd = rd_i & ~empty_o;

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == (PtrWidth+1)'(FifoDepth));

  // Head of queue, valid one cycle after the write
  assign data_o = mem[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr_q <= wr_ptr_q + PtrWidth'(1);
      end
      if (do_rd) begin
        rd_ptr_q <= rd_ptr_q + PtrWidth'(1);
      end
      case ({do_wr, do_rd})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Switch control must never pop an empty queue
  a_no_read_empty: assert property (@(posedge clk) disable iff (rst) rd_i |-> !empty_o)
    else $error("input FIFO read while empty");

  // Sender has to honour stop_o
  a_no_write_full: assert property (@(posedge clk) disable iff (rst) wr_i |-> !full_o)
    else $error("input FIFO written while full");

endmodule

/* router_arbiter.sv */
/*
 * Round-robin arbiter for one output port
 *   rotating search starting after the last winner
 *   priority pointer advanced on the tail forward
 */
`timescale 1ns/10ps

module router_arbiter (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [noc_pkg::NumPorts-1:0] request_i,
  input  logic                         advance_i,
  output noc_pkg::direction_t          grant_o,
  output logic                         grant_valid_o
);
  import noc_pkg::*;

  // Input that finished the last worm
  logic [2:0] last_q;
  logic [2:0] winner;

  // Walk the inputs once from just past the last winner
  always_comb begin
    int   idx;
    logic found;
    grant_o = '0;
    winner  = last_q;
    found   = 1'b0;
    for (int k = 1; k <= NumPorts; k++) begin
      idx = (int'(last_q) + k) % NumPorts;
      if (!found && request_i[idx]) begin
        grant_o[idx] = 1'b1;
        winner       = 3'(idx);
        found        = 1'b1;
      end
    end
  end

  assign grant_valid_o = |grant_o;

  // Reset value makes north the first in line
  always_ff @(posedge clk) begin
    if (rst) begin
      last_q <= kLocalPort;
    end else if (advance_i) begin
      last_q <= winner;
    end
  end

  a_grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant_o))
    else $error("arbiter grant not one-hot");

endmodule

/* router_lookahead.sv */
/*
 * Look-ahead routing for one output
 *   position of the neighbour behind the output
 *   XY step that neighbour will take
 */
`timescale 1ns/10ps

module router_lookahead (
  input  noc_pkg::xy_t        position_i,
  input  noc_pkg::port_e      out_port_i,
  input  noc_pkg::xy_t        destination_i,
  output noc_pkg::direction_t routing_o
);
  import noc_pkg::*;

  // Router one hop away through this output
  xy_t neighbour;

  always_comb begin
    neighbour = position_i;
    case (out_port_i)
      kNorthPort: begin
        neighbour.y = position_i.y - 3'd1;
      end
      kSouthPort: begin
        neighbour.y = position_i.y + 3'd1;
      end
      kWestPort: begin
        neighbour.x = position_i.x - 3'd1;
      end
      kEastPort: begin
        neighbour.x = position_i.x + 3'd1;
      end
      default: begin
        // Local output, no hop
        neighbour = position_i;
      end
    endcase
  end

  // Ejected flits keep pointing at local
  assign routing_o = (out_port_i == kLocalPort) ? GoLocal : next_hop(neighbour, destination_i);

endmodule

/* router_switch_ctrl.sv */
/*
 * Switch control for all five outputs
 *   request matrix from the routing field of valid head flits
 *   one round-robin arbiter and one wormhole FSM per output
 *   input select, forward strobe and FIFO read strobes
 */
`timescale 1ns/10ps

module router_switch_ctrl (
  input  logic                                           clk,
  input  logic                                           rst,
  input  flit_pkg::flit_t     [noc_pkg::NumPorts-1:0]    head_flit_i,
  input  logic                [noc_pkg::NumPorts-1:0]    empty_i,
  input  logic                [noc_pkg::NumPorts-1:0]    stop_i,
  output logic                [noc_pkg::NumPorts-1:0]    rd_o,
  output noc_pkg::direction_t [noc_pkg::NumPorts-1:0]    select_o,
  output logic                [noc_pkg::NumPorts-1:0]    forward_o
);
  import noc_pkg::*;
  import flit_pkg::*;

  // Wormhole FSM encoding
  localparam logic [1:0] StReserve = 2'd0;
  localparam logic [1:0] StHead    = 2'd1;
  localparam logic [1:0] StPayload = 2'd2;

  logic [NumPorts-1:0] valid_head;

  // Indexed [output][input]
  logic [NumPorts-1:0][NumPorts-1:0] request;
  // Indexed [input][output]
  logic [NumPorts-1:0][NumPorts-1:0] read_matrix;

  ////////////////////////////////////////////////////////////////////////////
  // Input side
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NumPorts; i++) begin : gen_input
    // Only a present head flit asks for an output
    assign valid_head[i] = ~empty_i[i] & head_flit_i[i].header.preamble.head;

    // At most one output may pop this input per cycle
    assign rd_o[i] = |read_matrix[i];

    a_single_reader: assert property (@(posedge clk) disable iff (rst)
      $onehot0(read_matrix[i]))
      else $error("input read by two outputs in one cycle");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output side
  ////////////////////////////////////////////////////////////////////////////

  for (genvar o = 0; o < NumPorts; o++) begin : gen_output
    logic [1:0]          state_q;
    logic [1:0]          state_d;
    direction_t          select_q;
    direction_t          select_d;
    logic [NumPorts-1:0] arb_request;
    direction_t          grant;
    logic                grant_valid;
    logic                sel_present;
    logic                sel_tail;
    logic                advance;
    flit_t               sel_flit;

    // U-turns back to the same port are not routed
    for (genvar i = 0; i < NumPorts; i++) begin : gen_request
      assign request[o][i] = (i != o) && valid_head[i] && head_flit_i[i].header.routing[o];
      assign read_matrix[i][o] = forward_o[o] & select_o[o][i];
    end

    // While bound, the arbiter only sees the bound input
    // so its winner at the tail is that input
    assign arb_request = (state_q == StReserve) ? request[o] : select_q;

    router_arbiter i_arbiter (
      .clk           (clk),
      .rst           (rst),
      .request_i     (arb_request),
      .advance_i     (advance),
      .grant_o       (grant),
      .grant_valid_o (grant_valid)
    );

    // Idle output takes the fresh grant in the same cycle
    assign select_o[o] = (state_q == StReserve) ? grant : select_q;

    // Flit at the head of the selected queue
    always_comb begin
      sel_flit = '0;
      for (int i = 0; i < NumPorts; i++) begin
        if (select_o[o][i]) begin
          sel_flit = head_flit_i[i];
        end
      end
    end

    assign sel_present  = |(select_o[o] & ~empty_i);
    assign sel_tail     = sel_flit.header.preamble.tail;
    assign forward_o[o] = sel_present & ~stop_i[o];
    assign advance      = forward_o[o] & sel_tail;

    always_comb begin
      state_d  = state_q;
      select_d = select_q;
      // Bind on grant, head may still be stopped
      if (state_q == StReserve && grant_valid) begin
        select_d = grant;
        state_d  = StHead;
      end
      if (forward_o[o]) begin
        state_d = sel_tail ? StReserve : StPayload;
      end
      // Release the input after the tail
      if (advance) begin
        select_d = '0;
      end
    end

    always_ff @(posedge clk) begin
      if (rst) begin
        state_q  <= StReserve;
        select_q <= '0;
      end else begin
        state_q  <= state_d;
        select_q <= select_d;
      end
    end

    a_select_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(select_o[o]))
      else $error("output select not one-hot");

    // A bound but unsent worm must still show its head
    a_head_waits: assert property (@(posedge clk) disable iff (rst)
      (state_q == StHead && sel_present) |-> sel_flit.header.preamble.head)
      else $error("bound worm lost its head flit");
  end

endmodule

/* router_output_stage.sv */
/*
 * Output stage for all five outputs
 *   crossbar from the FIFO heads
 *   routing field rewrite on head flits
 *   output registers and void flags
 */
`timescale 1ns/10ps

module router_output_stage (
  input  logic                                        clk,
  input  logic                                        rst,
  input  noc_pkg::xy_t                                position_i,
  input  flit_pkg::flit_t     [noc_pkg::NumPorts-1:0] head_flit_i,
  input  noc_pkg::direction_t [noc_pkg::NumPorts-1:0] select_i,
  input  logic                [noc_pkg::NumPorts-1:0] forward_i,
  input  logic                [noc_pkg::NumPorts-1:0] stop_i,
  output flit_pkg::flit_t     [noc_pkg::NumPorts-1:0] data_o,
  output logic                [noc_pkg::NumPorts-1:0] data_void_o
);
  import noc_pkg::*;
  import flit_pkg::*;

  for (genvar o = 0; o < NumPorts; o++) begin : gen_output
    flit_t      cross_flit;
    flit_t      next_flit;
    flit_t      data_q;
    direction_t routing;
    logic       void_q;

    // Crossbar column for this output
    always_comb begin
      cross_flit = '0;
      for (int i = 0; i < NumPorts; i++) begin
        if (select_i[o][i]) begin
          cross_flit = head_flit_i[i];
        end
      end
    end

    router_lookahead i_lookahead (
      .position_i    (position_i),
      .out_port_i    (port_e'(o)),
      .destination_i (cross_flit.header.destination),
      .routing_o     (routing)
    );

    // Head flit carries the next router's output and body flits pass as is
    always_comb begin
      next_flit = cross_flit;
      if (cross_flit.header.preamble.head) begin
        next_flit.header.routing = routing;
      end
    end

    always_ff @(posedge clk) begin
      if (forward_i[o]) begin
        data_q <= next_flit;
      end
    end

    // Void goes low on a forward and high after a plain transfer, and holds under stop
    always_ff @(posedge clk) begin
      if (rst) begin
        void_q <= 1'b1;
      end else if (forward_i[o]) begin
        void_q <= 1'b0;
      end else if (!stop_i[o]) begin
        void_q <= 1'b1;
      end
    end

    assign data_o[o]      = data_q;
    assign data_void_o[o] = void_q;
  end

endmodule

/* mesh_router.sv */
/*
 * Five-port mesh router top level
 *   one input FIFO per port
 *   switch control with arbiters and wormhole FSMs
 *   output stage with crossbar and look-ahead rewrite
 */
`timescale 1ns/10ps

module mesh_router #(
  parameter int unsigned FifoDepth = 4
) (
  input  logic                         clk,
  input  logic                         rst,
  input  noc_pkg::xy_t                 position_i,
  // Input links
  input  flit_pkg::flit_t              data_n_i,
  input  flit_pkg::flit_t              data_s_i,
  input  flit_pkg::flit_t              data_w_i,
  input  flit_pkg::flit_t              data_e_i,
  input  flit_pkg::flit_t              data_p_i,
  input  logic [noc_pkg::NumPorts-1:0] data_void_i,
  output logic [noc_pkg::NumPorts-1:0] stop_o,
  // Output links
  output flit_pkg::flit_t              data_n_o,
  output flit_pkg::flit_t              data_s_o,
  output flit_pkg::flit_t              data_w_o,
  output flit_pkg::flit_t              data_e_o,
  output flit_pkg::flit_t              data_p_o,
  output logic [noc_pkg::NumPorts-1:0] data_void_o,
  input  logic [noc_pkg::NumPorts-1:0] stop_i
);
  import noc_pkg::*;
  import flit_pkg::*;

  flit_t      [NumPorts-1:0] data_in;
  flit_t      [NumPorts-1:0] fifo_head;
  flit_t      [NumPorts-1:0] data_out;
  logic       [NumPorts-1:0] empty;
  logic       [NumPorts-1:0] full;
  logic       [NumPorts-1:0] rd;
  logic       [NumPorts-1:0] forward;
  direction_t [NumPorts-1:0] select;

  // Gather the link inputs by port index
  assign data_in[kNorthPort] = data_n_i;
  assign data_in[kSouthPort] = data_s_i;
  assign data_in[kWestPort]  = data_w_i;
  assign data_in[kEastPort]  = data_e_i;
  assign data_in[kLocalPort] = data_p_i;

  ////////////////////////////////////////////////////////////////////////////
  // Input queues
  ////////////////////////////////////////////////////////////////////////////

  for (genvar p = 0; p < NumPorts; p++) begin : gen_fifo
    router_input_fifo #(
      .FifoDepth (FifoDepth)
    ) i_fifo (
      .clk     (clk),
      .rst     (rst),
      .data_i  (data_in[p]),
      .wr_i    (~data_void_i[p]),
      .rd_i    (rd[p]),
      .data_o  (fifo_head[p]),
      .empty_o (empty[p]),
      .full_o  (full[p])
    );
  end

  // Back-pressure towards the sender is the full flag
  assign stop_o = full;

  ////////////////////////////////////////////////////////////////////////////
  // Control and datapath
  ////////////////////////////////////////////////////////////////////////////

  router_switch_ctrl i_switch_ctrl (
    .clk         (clk),
    .rst         (rst),
    .head_flit_i (fifo_head),
    .empty_i     (empty),
    .stop_i      (stop_i),
    .rd_o        (rd),
    .select_o    (select),
    .forward_o   (forward)
  );

  router_output_stage i_output_stage (
    .clk         (clk),
    .rst         (rst),
    .position_i  (position_i),
    .head_flit_i (fifo_head),
    .select_i    (select),
    .forward_i   (forward),
    .stop_i      (stop_i),
    .data_o      (data_out),
    .data_void_o (data_void_o)
  );

  assign data_n_o = data_out[kNorthPort];
  assign data_s_o = data_out[kSouthPort];
  assign data_w_o = data_out[kWestPort];
  assign data_e_o = data_out[kEastPort];
  assign data_p_o = data_out[kLocalPort];

endmodule

/* tb_mesh_router.sv */
/*
 * Testbench for the five-port mesh router at position (2,2)
 *   clock, reset, link drivers and stop patterns
 *   per-output scoreboard queues with the look-ahead routing model
 *   concurrent checks on every transferred flit and on held outputs
 *   test sequence, watchdog and closing report
 */
`timescale 1ns/10ps

module tb_mesh_router;
  import noc_pkg::*;
  import flit_pkg::*;

  localparam int  ClkPeriod  = 40;
  localparam int  FifoDepth  = 4;
  localparam int  NumTests   = 6;
  localparam int  TestCycles = 2000;
  localparam xy_t RouterPos  = '{x: 3'd2, y: 3'd2};

  logic                clk;
  logic                rst;
  flit_t               link_in  [NumPorts];
  flit_t               link_out [NumPorts];
  logic [NumPorts-1:0] void_in;
  logic [NumPorts-1:0] void_out;
  logic [NumPorts-1:0] stop_in;
  logic [NumPorts-1:0] stop_out;
  logic [NumPorts-1:0] xfer;

  // Scoreboard with one queue of expected flits per output
  flit_t       exp_q     [NumPorts][$];
  flit_t       exp_front [NumPorts];
  int unsigned exp_count [NumPorts];

  int errors;
  int tests_run;
  int tests_bad;
  int errors_at_start;
  bit idle_phase;

  mesh_router #(
    .FifoDepth (FifoDepth)
  ) i_dut (
    .clk         (clk),
    .rst         (rst),
    .position_i  (RouterPos),
    .data_n_i    (link_in[kNorthPort]),
    .data_s_i    (link_in[kSouthPort]),
    .data_w_i    (link_in[kWestPort]),
    .data_e_i    (link_in[kEastPort]),
    .data_p_i    (link_in[kLocalPort]),
    .data_void_i (void_in),
    .stop_o      (stop_out),
    .data_n_o    (link_out[kNorthPort]),
    .data_s_o    (link_out[kSouthPort]),
    .data_w_o    (link_out[kWestPort]),
    .data_e_o    (link_out[kEastPort]),
    .data_p_o    (link_out[kLocalPort]),
    .data_void_o (void_out),
    .stop_i      (stop_in)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  // A flit leaves at the rising edge where it is valid and not stopped
  assign xfer = ~void_out & ~stop_in;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic xy_t grid_point(input int x, input int y);
    xy_t p;
    p.x = 3'(x);
    p.y = 3'(y);
    return p;
  endfunction

  // XY order settles x first, then y, then ejects
  function automatic direction_t route_from(input xy_t here, input xy_t dest);
    if (dest.x != here.x) begin
      return (dest.x > here.x) ? 5'b01000 : 5'b00100;
    end
    if (dest.y != here.y) begin
      return (dest.y > here.y) ? 5'b00010 : 5'b00001;
    end
    return 5'b10000;
  endfunction

  // North is y minus one and east is x plus one
  function automatic xy_t neighbour_of(input xy_t here, input int port);
    xy_t n;
    n = here;
    case (port)
      0: n.y = here.y - 3'd1;
      1: n.y = here.y + 3'd1;
      2: n.x = here.x - 3'd1;
      3: n.x = here.x + 3'd1;
      default: n = here;
    endcase
    return n;
  endfunction

  function automatic int port_of(input direction_t dir);
    int p;
    p = 0;
    for (int k = 0; k < NumPorts; k++) begin
      if (dir[k]) begin
        p = k;
      end
    end
    return p;
  endfunction

  // Head leaves with the routing the next router needs
  function automatic flit_t expect_flit(input flit_t f, input int out);
    flit_t e;
    e = f;
    if (f.header.preamble.head) begin
      if (out == kLocalPort) begin
        e.header.routing = 5'b10000;
      end else begin
        e.header.routing = route_from(neighbour_of(RouterPos, out), f.header.destination);
      end
    end
    return e;
  endfunction

  // Every head gets random source, message and reserved bits
  function automatic flit_t make_head(input xy_t dest, input logic tail);
    flit_t f;
    f.payload                = {2'b00, $urandom};
    f.header.preamble.head   = 1'b1;
    f.header.preamble.tail   = tail;
    f.header.destination     = dest;
    f.header.routing         = route_from(RouterPos, dest);
    return f;
  endfunction

  function automatic flit_t make_body(input logic tail);
    flit_t f;
    f.payload = {1'b0, tail, $urandom};
    return f;
  endfunction

  function automatic void refresh_front(input int out);
    exp_count[out] = exp_q[out].size();
    exp_front[out] = (exp_q[out].size() > 0) ? exp_q[out][0] : '0;
  endfunction

  function automatic int queued_total();
    int total;
    total = 0;
    for (int o = 0; o < NumPorts; o++) begin
      total += exp_q[o].size();
    end
    return total;
  endfunction

  // Pop after the check at the falling edge has sampled the front
  always @(negedge clk) begin
    #1;
    if (!rst) begin
      for (int o = 0; o < NumPorts; o++) begin
        if (xfer[o] && exp_q[o].size() > 0) begin
          exp_q[o].delete(0);
          refresh_front(o);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  a_idle_after_reset: assert property (@(negedge clk) disable iff (rst)
    idle_phase |-> (void_out == '1 && stop_out == '0))
    else begin
      errors++;
      $display("[FAIL] %0d ns: router not idle after reset", $time);
    end

  for (genvar o = 0; o < NumPorts; o++) begin : gen_check
    a_flit_known: assert property (@(negedge clk) disable iff (rst)
      xfer[o] |-> exp_count[o] != 0)
      else begin
        errors++;
        $display("output %0d sent a flit that nobody sent in at %0d ns", o, $time);
      end

    a_flit_value: assert property (@(negedge clk) disable iff (rst)
      (xfer[o] && exp_count[o] != 0) |-> link_out[o] == exp_front[o])
      else begin
        errors++;
        $display("[FAIL] %0d ns: output %0d flit %h, expected %h",
                 $time, o, link_out[o], exp_front[o]);
      end

    // Held output must not move while its receiver stops it
    a_held_under_stop: assert property (@(negedge clk) disable iff (rst)
      (stop_in[o] && !void_out[o]) |=> ($stable(link_out[o]) && $stable(void_out[o])))
      else begin
        errors++;
        $display("[FAIL] %0d ns: output %0d changed while stopped", $time, o);
      end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////////////////////////////////////////

  // Offer one flit and wait while the input queue is full
  task automatic send_flit(input int port, input flit_t f);
    while (stop_out[port]) begin
      @(posedge clk);
      #2;
    end
    link_in[port] = f;
    void_in[port] = 1'b0;
    @(posedge clk);
    #2;
    void_in[port] = 1'b1;
  endtask

  // Whole worm goes on the scoreboard before its first flit is offered
  task automatic send_worm(input int in_port, input xy_t dest, input int len);
    flit_t worm [$];
    flit_t f;
    int    out;
    out = port_of(route_from(RouterPos, dest));
    for (int k = 0; k < len; k++) begin
      f = (k == 0) ? make_head(dest, len == 1) : make_body(k == len - 1);
      worm.push_back(f);
      exp_q[out].push_back(expect_flit(f, out));
      refresh_front(out);
    end
    foreach (worm[k]) begin
      send_flit(in_port, worm[k]);
    end
  endtask

  task automatic wait_stop_level(input int port, input logic level, input int limit,
                                 output bit seen);
    int n;
    n    = 0;
    seen = (stop_out[port] == level);
    while (!seen && n < limit) begin
      @(posedge clk);
      #2;
      n++;
      seen = (stop_out[port] == level);
    end
  endtask

  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while (queued_total() != 0 && n < limit) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (queued_total() != 0) begin
      errors++;
      $display("%0d flits never left the router within %0d cycles", queued_total(), limit);
    end
    repeat (2) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic start_test();
    errors_at_start = errors;
    tests_run++;
  endtask

  task automatic finish_test(input string name);
    wait_drain(200);
    if (errors == errors_at_start) begin
      $display("test %0d %s: clean", tests_run, name);
    end else begin
      tests_bad++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - errors_at_start);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    bit seen;
    void'($urandom(32'ha8aea82e));
    clk        = 1'b0;
    rst        = 1'b1;
    void_in    = '1;
    stop_in    = '0;
    idle_phase = 1'b1;
    errors     = 0;
    tests_run  = 0;
    tests_bad  = 0;
    for (int p = 0; p < NumPorts; p++) begin
      link_in[p] = '0;
      refresh_front(p);
    end
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;

    start_test();
    repeat (4) begin
      @(posedge clk);
      #2;
    end
    idle_phase = 1'b0;
    finish_test("reset_state");

    // One packet per direction and the local one has to come from outside
    start_test();
    send_worm(kLocalPort, grid_point(3, 2), 1);
    send_worm(kLocalPort, grid_point(2, 0), 1);
    send_worm(kLocalPort, grid_point(2, 4), 1);
    send_worm(kLocalPort, grid_point(0, 1), 1);
    send_worm(kNorthPort, grid_point(2, 2), 1);
    finish_test("lookahead_routing");

    start_test();
    fork
      send_worm(kWestPort, grid_point(2, 0), 5);
      send_worm(kEastPort, grid_point(2, 5), 5);
    join
    finish_test("worm_order");

    // Second worm starts a cycle later and must wait for the first tail
    start_test();
    fork
      send_worm(kWestPort, grid_point(4, 2), 4);
      begin
        @(posedge clk);
        #2;
        send_worm(kNorthPort, grid_point(3, 3), 4);
      end
    join
    finish_test("contention");

    start_test();
    stop_in[kEastPort] = 1'b1;
    fork
      send_worm(kLocalPort, grid_point(5, 1), 6);
      begin
        repeat (6) begin
          @(posedge clk);
          #2;
        end
        repeat (40) begin
          stop_in[kEastPort] = ($urandom_range(0, 1) != 0);
          @(posedge clk);
          #2;
        end
        stop_in[kEastPort] = 1'b0;
      end
    join
    finish_test("back_pressure");

    start_test();
    stop_in[kEastPort] = 1'b1;
    fork
      for (int k = 0; k <= FifoDepth; k++) begin
        send_worm(kLocalPort, grid_point(6, 3), 1);
      end
      begin
        wait_stop_level(kLocalPort, 1'b1, 20, seen);
        a_stop_rises: assert (seen) else begin
          errors++;
          $display("stop_o of the local input did not rise with east held");
        end
        stop_in[kEastPort] = 1'b0;
        wait_stop_level(kLocalPort, 1'b0, 20, seen);
        a_stop_falls: assert (seen) else begin
          errors++;
          $display("stop_o of the local input stayed high after east was released");
        end
      end
    join
    finish_test("fifo_full");

    $display("summary: %0d tests run, %0d with errors, %0d errors in total",
             tests_run, tests_bad, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Bound on the whole run
  initial begin
    #(NumTests * TestCycles * ClkPeriod);
    $display("timeout: the run did not finish in %0d cycles", NumTests * TestCycles);
    $display("tests failed");
    $finish;
  end

endmodule

/* vlog.f */
noc_pkg.sv
flit_pkg.sv
router_input_fifo.sv
router_arbiter.sv
router_lookahead.sv
router_switch_ctrl.sv
router_output_stage.sv
mesh_router.sv
tb_mesh_router.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the mesh router testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
  --top-module tb_mesh_router -f vlog.f
./obj_dir/Vtb_mesh_router | tee sim.log

if grep -qx "all tests passed" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
